//--- bench/approx_mac_tests.txt
# name x y last hold product (x, y, product in hex)
# out_hold follows the hold column from the line's strobe onward
t_zero      0000 1234 0 0 00018000
t_pos       0040 0003 0 0 000180c0
t_neg       ffc0 0005 0 0 00017ec0
t_min_max   8000 7fff 1 0 c0020000
t_min_min   8000 8000 0 0 40018000
t_mixed     0100 ff00 0 0 00008000
t_max_y     7fc0 7fff 1 0 3fe10040
h01         0040 0001 0 1 00018040
h02         0080 0002 0 1 00018100
h03         00c0 ffff 0 1 00017f40
h04         0100 0010 0 1 00019000
h05         ff00 0004 1 1 00017c00
h06         0200 0100 0 1 00038000
h07         1000 1000 0 1 01018000
h08         f000 1000 0 1 ff018000
h09         0040 8000 0 1 ffe18000
h10         0000 7fff 1 1 00018000
h11         0400 0002 0 1 00018800
h12         0080 0080 0 1 0001c000
r01         0040 0040 0 0 00019000
r02         ffc0 ffc0 1 0 00019000

//--- list.f
+incdir+rtl
rtl/mac_pkg.sv
rtl/pair_stream_if.sv
rtl/pair_capture.sv
rtl/pair_fifo.sv
rtl/approx_mult_16.sv
rtl/mac_unit.sv
rtl/approx_mac_top.sv
bench/clk_gen.sv
bench/approx_mac_chk.sv
bench/approx_mac_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= approx_mac_tb
RTL_TOP   ?= approx_mac_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Irtl --top-module $(RTL_TOP) \
		rtl/mac_pkg.sv rtl/pair_stream_if.sv rtl/pair_capture.sv rtl/pair_fifo.sv \
		rtl/approx_mult_16.sv rtl/mac_unit.sv rtl/approx_mac_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/approx_mac_tb.sv
`timescale 1ns/1ps
`include "mac_macros.svh"

module approx_mac_tb;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    logic [`MAC_OP_W-1:0]  in_x;
    logic [`MAC_OP_W-1:0]  in_y;
    logic                  in_last;
    logic                  out_hold;
    logic                  out_valid;
    mac_pkg::product_t     out_product;
    logic                  sum_valid;
    mac_pkg::acc_t         out_sum;
    logic                  full;
    logic                  overflow;

    // test table
    string                  t_name [$];
    logic [`MAC_OP_W-1:0]   t_x [$];
    logic [`MAC_OP_W-1:0]   t_y [$];
    logic                   t_last [$];
    logic                   t_hold [$];
    logic [`MAC_PROD_W-1:0] t_prod [$];

    // line currently driven
    string                  cur_name;
    logic [`MAC_PROD_W-1:0] cur_exp;

    // reference model of the buffer
    int                     model_count;
    logic                   model_ovf;
    logic                   model_pop;
    logic                   pend_valid;
    logic                   pend_accept;
    string                  pend_name;
    logic [`MAC_PROD_W-1:0] pend_exp;
    logic                   pend_last;
    logic [`MAC_ACC_W-1:0]  run_sum;
    string                  exp_name [$];
    logic [`MAC_ACC_W-1:0]  exp_prod [$];
    string                  sum_name [$];
    logic [`MAC_ACC_W-1:0]  exp_sum [$];

    int cycle_count;
    int cycle_limit;

    clk_gen #(.PERIOD(40.0)) clk_inst (.clk(clk));

    approx_mac_top approx_mac_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_x        (in_x),
        .in_y        (in_y),
        .in_last     (in_last),
        .out_hold    (out_hold),
        .out_valid   (out_valid),
        .out_product (out_product),
        .sum_valid   (sum_valid),
        .out_sum     (out_sum),
        .full        (full),
        .overflow    (overflow)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [`MAC_ACC_W-1:0] expected,
                               input logic [`MAC_ACC_W-1:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic read_tests();
        int                     fd;
        int                     rc;
        int                     vl;
        int                     vh;
        string                  line;
        string                  nm;
        logic [`MAC_OP_W-1:0]   vx;
        logic [`MAC_OP_W-1:0]   vy;
        logic [`MAC_PROD_W-1:0] vp;
        fd = $fopen("bench/approx_mac_tests.txt", "r");
        if (fd == 0) begin
            stop_run("could not open the test file bench/approx_mac_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;    // comment or blank
            end
            rc = $sscanf(line, "%s %h %h %d %d %h", nm, vx, vy, vl, vh, vp);
            if (rc != 6) begin
                stop_run($sformatf("malformed line in the test file: %s", line));
            end
            t_name.push_back(nm);
            t_x.push_back(vx);
            t_y.push_back(vy);
            t_last.push_back(vl != 0);
            t_hold.push_back(vh != 0);
            t_prod.push_back(vp);
        end
        $fclose(fd);
    endtask

    // mirror of capture, buffer and accumulator, plus output checks
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_count = 0;
            model_ovf   = 1'b0;
            pend_valid  = 1'b0;
            run_sum     = '0;
        end else begin
            check_value("full", 40'(model_count == `MAC_FIFO_DEPTH), 40'(full));
            check_value("overflow", 40'(model_ovf), 40'(overflow));
            if (out_valid) begin
                if (exp_prod.size() == 0) begin
                    stop_run("a product came out that no accepted pair accounts for");
                end
                check_value(exp_name.pop_front(), exp_prod.pop_front(),
                            {{8{out_product[31]}}, out_product});
            end
            if (sum_valid) begin
                if (exp_sum.size() == 0) begin
                    stop_run("a sum came out that no last pair accounts for");
                end
                check_value(sum_name.pop_front(), exp_sum.pop_front(), out_sum);
            end
            pend_accept = pend_valid && model_count < `MAC_FIFO_DEPTH;
            model_pop   = model_count > 0 && !out_hold;
            if (pend_valid && !pend_accept) begin
                model_ovf = 1'b1;    // dropped at the capture stage
            end else if (pend_accept) begin
                exp_name.push_back(pend_name);
                exp_prod.push_back({{8{pend_exp[31]}}, pend_exp});
                run_sum = run_sum + {{8{pend_exp[31]}}, pend_exp};
                if (pend_last) begin
                    sum_name.push_back({pend_name, "_sum"});
                    exp_sum.push_back(run_sum);
                    run_sum = '0;
                end
            end
            if (model_pop) begin
                model_count = model_count - 1;
            end
            if (pend_accept) begin
                model_count = model_count + 1;
            end
            pend_valid = in_valid;
            pend_name  = cur_name;
            pend_exp   = cur_exp;
            pend_last  = in_last;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        int gap;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_x        = '0;
        in_y        = '0;
        in_last     = 1'b0;
        out_hold    = 1'b0;
        cur_name    = "none";
        cur_exp     = '0;
        cycle_count = 0;
        cycle_limit = 0;
        void'($urandom(32'h7838_81fc));
        read_tests();
        cycle_limit = 4 * t_name.size() + 200;

        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("reset_out_valid", 40'(0), 40'(out_valid));
        check_value("reset_sum_valid", 40'(0), 40'(sum_valid));
        check_value("reset_full", 40'(0), 40'(full));
        check_value("reset_overflow", 40'(0), 40'(overflow));
        @(posedge clk);
        arst_n <= 1'b1;

        for (int k = 0; k < t_name.size(); k++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_x     <= t_x[k];
            in_y     <= t_y[k];
            in_last  <= t_last[k];
            out_hold <= t_hold[k];
            cur_name <= t_name[k];
            cur_exp  <= t_prod[k];
            gap = $urandom % 3;
            @(posedge clk);
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        @(posedge clk);
        out_hold <= 1'b0;

        // drain whatever is still buffered
        do begin
            @(negedge clk);
        end while (pend_valid || model_count != 0);
        repeat (2) @(negedge clk);

        if (exp_prod.size() != 0 || exp_sum.size() != 0) begin
            $display("expected results were left over at the end of the run");
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- bench/approx_mac_chk.sv
`timescale 1ns/1ps

module approx_mac_chk (
    input logic clk,
    input logic arst_n,
    input logic out_hold,
    input logic out_valid,
    input logic sum_valid,
    input logic full,
    input logic overflow,
    input logic buf_strobe    // buffer not empty
);

    sum_with_product: assert property (@(posedge clk) disable iff (!arst_n)
        sum_valid |-> out_valid)
        else $error("sum_valid without out_valid");

    overflow_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        !$fell(overflow))
        else $error("overflow cleared without reset");

    no_output_on_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_hold |=> !out_valid)
        else $error("out_valid after a held cycle");

    full_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
        full |=> buf_strobe)
        else $error("buffer empty right after it was full");

endmodule

bind approx_mac_top approx_mac_chk chk_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_hold   (out_hold),
    .out_valid  (out_valid),
    .sum_valid  (sum_valid),
    .full       (full),
    .overflow   (overflow),
    .buf_strobe (buf_if.strobe)
);

//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter realtime PERIOD = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- rtl/approx_mac_top.sv
`timescale 1ns/1ps
`include "mac_macros.svh"

module approx_mac_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  logic [`MAC_OP_W-1:0] in_x,
    input  logic [`MAC_OP_W-1:0] in_y,
    input  logic                 in_last,
    input  logic                 out_hold,
    output logic                 out_valid,
    output mac_pkg::product_t    out_product,
    output logic                 sum_valid,
    output mac_pkg::acc_t        out_sum,
    output logic                 full,
    output logic                 overflow
);

    pair_stream_if cap_if ();    // capture -> buffer
    pair_stream_if buf_if ();    // buffer -> mac

    pair_capture cap_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_x     (in_x),
        .in_y     (in_y),
        .in_last  (in_last),
        .out      (cap_if.src),
        .overflow (overflow)
    );

    pair_fifo #(
        .payload_t (mac_pkg::operand_pair_t)
    ) fifo_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (cap_if.dst),
        .rd     (buf_if.src)
    );

    mac_unit mac_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .in          (buf_if.dst),
        .stall       (out_hold),
        .out_valid   (out_valid),
        .out_product (out_product),
        .sum_valid   (sum_valid),
        .out_sum     (out_sum)
    );

    assign full = cap_if.hold;

endmodule

//--- rtl/mac_unit.sv
`timescale 1ns/1ps

module mac_unit (
    input  logic              clk,
    input  logic              arst_n,
    pair_stream_if.dst        in,
    input  logic              stall,
    output logic              out_valid,
    output mac_pkg::product_t out_product,
    output logic              sum_valid,
    output mac_pkg::acc_t     out_sum
);

    mac_pkg::product_t prod;
    mac_pkg::acc_t     acc;
    mac_pkg::acc_t     acc_next;
    logic              take;

    approx_mult_16 mult_inst (
        .x (in.pair.x),
        .y (in.pair.y),
        .z (prod)
    );

    assign in.hold  = stall;
    assign take     = in.strobe & ~stall;
    assign acc_next = acc + mac_pkg::acc_t'(prod);    // sign extended

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            sum_valid <= 1'b0;
            acc       <= '0;
        end else begin
            out_valid <= take;
            sum_valid <= take & in.pair.last;
            if (take) begin
                acc <= in.pair.last ? '0 : acc_next;    // restart after last
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_product <= prod;
        end
        if (take && in.pair.last) begin
            out_sum <= acc_next;    // includes the last pair
        end
    end

endmodule

//--- rtl/approx_mult_16.sv
`timescale 1ns/1ps
`include "mac_macros.svh"

module approx_mult_16 (
    input  logic [`MAC_OP_W-1:0] x,
    input  logic [`MAC_OP_W-1:0] y,
    output mac_pkg::product_t    z
);

    // baugh-wooley partial product bit, row i (x) and column j (y)
    function automatic logic pbit(
        input logic [`MAC_OP_W-1:0] a,
        input logic [`MAC_OP_W-1:0] b,
        input int                   i,
        input int                   j
    );
        logic p;
        p = a[i] & b[j];
        if ((i == `MAC_OP_W - 1) != (j == `MAC_OP_W - 1)) begin
            p = ~p;    // sign terms inverted
        end
        return p;
    endfunction

    logic [20:0]             cv [5];    // correction vectors for rows 0..5
    logic [`MAC_OP_W-1:0]    pp_row;
    logic [`MAC_PROD_W-1:0]  sum_w;

    always_comb begin
        cv = '{default: '0};

        cv[0][4]  = pbit(x, y, 2, 1) & pbit(x, y, 3, 0);
        cv[0][5]  = pbit(x, y, 2, 2) & pbit(x, y, 3, 1);
        cv[0][6]  = pbit(x, y, 4, 2) ^ pbit(x, y, 5, 1);
        cv[0][9]  = pbit(x, y, 0, 9) ^ pbit(x, y, 1, 8);
        cv[0][10] = pbit(x, y, 0, 10) ^ pbit(x, y, 1, 9);
        cv[0][12] = pbit(x, y, 2, 9) & pbit(x, y, 3, 8);
        cv[0][13] = pbit(x, y, 4, 9) ^ pbit(x, y, 5, 8);
        cv[0][15] = pbit(x, y, 2, 12) & pbit(x, y, 3, 11);
        cv[0][16] = pbit(x, y, 4, 11) & pbit(x, y, 5, 10);
        cv[0][17] = pbit(x, y, 1, 15);
        cv[0][18] = pbit(x, y, 2, 15) & pbit(x, y, 3, 14);
        cv[0][19] = pbit(x, y, 4, 14) & pbit(x, y, 5, 13);
        cv[0][20] = pbit(x, y, 4, 15) & pbit(x, y, 5, 14);

        cv[1][5]  = pbit(x, y, 2, 3) ^ pbit(x, y, 3, 2);
        cv[1][9]  = pbit(x, y, 2, 7) ^ pbit(x, y, 3, 6);
        cv[1][12] = pbit(x, y, 4, 8) ^ pbit(x, y, 5, 7);
        cv[1][15] = pbit(x, y, 2, 13) ^ pbit(x, y, 3, 12);
        cv[1][17] = 1'b1;    // absorbs the row 1 sign OR
        cv[1][18] = pbit(x, y, 3, 15);
        cv[1][19] = pbit(x, y, 4, 15) ^ pbit(x, y, 5, 14);
        cv[1][20] = pbit(x, y, 5, 15);

        cv[2][15] = pbit(x, y, 4, 10) | pbit(x, y, 5, 9);
        cv[2][17] = pbit(x, y, 2, 15) ^ pbit(x, y, 3, 14);
        cv[2][18] = pbit(x, y, 4, 14) ^ pbit(x, y, 5, 13);

        cv[3][15] = pbit(x, y, 4, 11) ^ pbit(x, y, 5, 10);
        cv[3][17] = pbit(x, y, 4, 12) & pbit(x, y, 5, 11);

        cv[4][17] = pbit(x, y, 4, 13) ^ pbit(x, y, 5, 12);

        sum_w = '0;
        for (int k = 0; k < 5; k++) begin
            sum_w = sum_w + `MAC_PROD_W'(cv[k]);
        end

        // exact rows 6..15
        for (int i = 6; i < `MAC_OP_W; i++) begin
            for (int j = 0; j < `MAC_OP_W; j++) begin
                pp_row[j] = pbit(x, y, i, j);
            end
            if (i == `MAC_OP_W - 1) begin
                sum_w = sum_w + {1'b1, pp_row, 15'b0};    // leading 1 of last row
            end else begin
                sum_w = sum_w + (`MAC_PROD_W'(pp_row) << i);
            end
        end
    end

    assign z = sum_w;

endmodule

//--- rtl/pair_fifo.sv
`timescale 1ns/1ps
`include "mac_macros.svh"

module pair_fifo #(
    parameter type payload_t = mac_pkg::operand_pair_t
) (
    input  logic       clk,
    input  logic       arst_n,
    pair_stream_if.dst wr,
    pair_stream_if.src rd
);

    localparam int DEPTH = `MAC_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    payload_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign push = wr.strobe;
    assign pop  = rd.strobe & ~rd.hold;

    assign wr.hold   = (count == (AW+1)'(DEPTH));    // full
    assign rd.strobe = (count != '0);                // not empty
    assign rd.pair   = mem[rd_ptr];                  // show-ahead head

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push+pop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.pair;
        end
    end

endmodule

//--- rtl/pair_capture.sv
`timescale 1ns/1ps
`include "mac_macros.svh"

module pair_capture (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  logic [`MAC_OP_W-1:0] in_x,
    input  logic [`MAC_OP_W-1:0] in_y,
    input  logic                 in_last,
    pair_stream_if.src           out,
    output logic                 overflow
);

    logic                   push_q;
    mac_pkg::operand_pair_t pair_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push_q   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            push_q <= in_valid;
            if (push_q && out.hold) begin
                overflow <= 1'b1;    // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pair_q.x    <= in_x;
            pair_q.y    <= in_y;
            pair_q.last <= in_last;
        end
    end

    // pair is dropped here when the buffer is full
    assign out.strobe = push_q & ~out.hold;
    assign out.pair   = pair_q;

endmodule

//--- rtl/pair_stream_if.sv
`timescale 1ns/1ps

interface pair_stream_if;

    logic                   strobe;    // item present
    mac_pkg::operand_pair_t pair;
    logic                   hold;      // receiver cannot accept

    modport src (
        output strobe,
        output pair,
        input  hold
    );

    modport dst (
        input  strobe,
        input  pair,
        output hold
    );

endinterface

//--- rtl/mac_pkg.sv
`include "mac_macros.svh"

package mac_pkg;

    typedef struct packed {
        logic signed [`MAC_OP_W-1:0] x;
        logic signed [`MAC_OP_W-1:0] y;
        logic                        last;    // closes a dot product
    } operand_pair_t;

    typedef logic signed [`MAC_PROD_W-1:0] product_t;

    typedef logic signed [`MAC_ACC_W-1:0] acc_t;

endpackage

//--- rtl/mac_macros.svh
`ifndef MAC_MACROS_SVH
`define MAC_MACROS_SVH

// operand and result widths
`define MAC_OP_W       16
`define MAC_PROD_W     32
`define MAC_ACC_W      40    // 8 guard bits over the product

// pair buffer
`define MAC_FIFO_DEPTH 8

`endif
